// ==== armController.f ====
hw/armCtrlPkg.sv
hw/instrDecoder.sv
hw/condUnit.sv
hw/executeStage.sv
hw/memWbStage.sv
hw/armController.sv
verif/armControllerProperties.sv
verif/tbArmController.sv

// ==== hw/armController.sv ====
`timescale 1ns/1ps
`default_nettype none

module armController (
  input  logic                             clk,
  input  logic                             rst,
  // Datapath side
  input  logic [31:0]                      InstrD,
  input  armCtrlPkg::flags_t               ALUFlagsE,
  input  logic [1:0]                       ALUResultLowE,
  // Hazard unit
  input  logic                             StallE,
  input  logic                             FlushE,
  input  logic                             StallM,
  input  logic                             FlushM,
  input  logic                             StallW,
  input  logic                             FlushW,
  // Decode selects
  output logic [1:0]                       RegSrcD,
  output logic [1:0]                       ImmSrcD,
  output logic                             ALUSrcD,
  // Execute
  output armCtrlPkg::aluOp_e               ALUControlE,
  output logic                             ALUSrcE,
  output logic                             BranchTakenE,
  output armCtrlPkg::flags_t               FlagsE,
  // Memory
  output logic                             MemWriteM,
  output logic                             MemtoRegM,
  output logic                             RegWriteM,
  output logic [armCtrlPkg::WordLanes-1:0] ByteMaskM,
  // Writeback
  output logic                             MemtoRegW,
  output logic                             RegWriteW,
  output logic                             PCSrcW
);
  import armCtrlPkg::*;

  decodeCtrl_t decodeCtrl;   // Decode bundle into E
  memCtrl_t    memCtrl;      // Condition-gated bundle into M

  instrDecoder instrDecoder_i (
    .InstrD     (InstrD),
    .RegSrcD    (RegSrcD),
    .ImmSrcD    (ImmSrcD),
    .ALUSrcD    (ALUSrcD),
    .decodeCtrl (decodeCtrl)
  );

  executeStage executeStage_i (
    .clk           (clk),
    .rst           (rst),
    .StallE        (StallE),
    .FlushE        (FlushE),
    .decodeCtrl    (decodeCtrl),
    .ALUFlagsE     (ALUFlagsE),
    .ALUResultLowE (ALUResultLowE),
    .ALUControlE   (ALUControlE),
    .ALUSrcE       (ALUSrcE),
    .BranchTakenE  (BranchTakenE),
    .FlagsE        (FlagsE),
    .memCtrl       (memCtrl)
  );

  memWbStage memWbStage_i (
    .clk       (clk),
    .rst       (rst),
    .StallM    (StallM),
    .FlushM    (FlushM),
    .StallW    (StallW),
    .FlushW    (FlushW),
    .memCtrl   (memCtrl),
    .MemWriteM (MemWriteM),
    .MemtoRegM (MemtoRegM),
    .RegWriteM (RegWriteM),
    .ByteMaskM (ByteMaskM),
    .MemtoRegW (MemtoRegW),
    .RegWriteW (RegWriteW),
    .PCSrcW    (PCSrcW)
  );

endmodule

`default_nettype wire

// ==== hw/armCtrlPkg.sv ====
`default_nettype none

package armCtrlPkg;

  // ======================================
  // Instruction field positions
  // ======================================
  localparam int CondMsb  = 31;  // Condition field
  localparam int CondLsb  = 28;
  localparam int OpMsb    = 27;  // Instruction class bits
  localparam int OpLsb    = 26;
  localparam int IBit     = 25;  // Immediate / register offset select
  localparam int DpOpMsb  = 24;  // Data-processing opcode
  localparam int DpOpLsb  = 21;
  localparam int UBit     = 23;  // Add or subtract offset
  localparam int BBit     = 22;  // Byte access
  localparam int LBit     = 20;  // Load when set
  localparam int SBit     = 20;  // Set flags, same bit as L
  localparam int RdMsb    = 15;  // Destination register
  localparam int RdLsb    = 12;
  localparam int UndefBit = 4;   // Set with I in the memory space is undefined

  localparam logic [3:0] PcReg = 4'd15;
  localparam int WordLanes = 4;  // Byte lanes in a 32-bit word

  // ======================================
  // Encodings
  // ======================================
  typedef enum logic [3:0] {
    AluAnd, AluEor, AluSub, AluRsb, AluAdd, AluAdc, AluSbc, AluRsc,
    AluTst, AluTeq, AluCmp, AluCmn, AluOrr, AluMov, AluBic, AluMvn
  } aluOp_e;

  typedef enum logic [3:0] {
    CondEq, CondNe, CondCs, CondCc, CondMi, CondPl, CondVs, CondVc,
    CondHi, CondLs, CondGe, CondLt, CondGt, CondLe, CondAl, CondNv
  } cond_e;

  typedef enum logic [1:0] {
    ClassDataProc, ClassMemAccess, ClassBranch, ClassNoOp
  } instrClass_e;

  // ======================================
  // Control bundles
  // ======================================
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    cond_e      cond;
    aluOp_e     aluControl;
    logic       aluSrc;
    logic       regWrite;
    logic       memWrite;
    logic       memtoReg;
    logic       branch;
    logic       pcSrc;
    logic [1:0] flagWrite;   // Bit 1 for N and Z, bit 0 for C and V
    logic       byteAccess;
  } decodeCtrl_t;

  typedef struct packed {
    logic                 memWrite;
    logic                 memtoReg;
    logic                 regWrite;
    logic                 pcSrc;
    logic [WordLanes-1:0] byteMask;
  } memCtrl_t;

  typedef struct packed {
    logic memtoReg;
    logic regWrite;
    logic pcSrc;
  } wbCtrl_t;

endpackage

`default_nettype wire

// ==== hw/condUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module condUnit (
  input  armCtrlPkg::cond_e  cond,        // Condition field of the instruction in E
  input  armCtrlPkg::flags_t flags,       // Current flags register
  input  armCtrlPkg::flags_t aluFlags,    // Flags from this instruction's ALU result
  input  logic [1:0]         flagWrite,   // Bit 1 for N and Z, bit 0 for C and V
  output logic               condEx,      // Instruction passes its condition
  output armCtrlPkg::flags_t nextFlags    // Flags value if the write happens
);
  import armCtrlPkg::*;

  logic signedGe;   // N equals V

  assign signedGe = (flags.n == flags.v);

  // ======================================
  // Condition check
  // ======================================
  always_comb begin
    case (cond)
      CondEq: condEx = flags.z;
      CondNe: condEx = ~flags.z;
      CondCs: condEx = flags.c;                  // Unsigned higher or same
      CondCc: condEx = ~flags.c;
      CondMi: condEx = flags.n;
      CondPl: condEx = ~flags.n;
      CondVs: condEx = flags.v;
      CondVc: condEx = ~flags.v;
      CondHi: condEx = flags.c & ~flags.z;       // Unsigned higher
      CondLs: condEx = ~flags.c | flags.z;
      CondGe: condEx = signedGe;
      CondLt: condEx = ~signedGe;
      CondGt: condEx = ~flags.z & signedGe;
      CondLe: condEx = flags.z | ~signedGe;
      CondAl: condEx = 1'b1;
      CondNv: condEx = 1'b0;                     // Never
      default: condEx = 1'b0;
    endcase
  end

  // ======================================
  // Next flags
  // ======================================
  // Each pair updates on its own enable, otherwise keeps the register value
  always_comb begin
    nextFlags = flags;
    if (flagWrite[1]) begin
      nextFlags.n = aluFlags.n;
      nextFlags.z = aluFlags.z;
    end
    if (flagWrite[0]) begin
      nextFlags.c = aluFlags.c;
      nextFlags.v = aluFlags.v;
    end
  end

endmodule

`default_nettype wire

// ==== hw/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    StallE,
  input  logic                    FlushE,
  input  armCtrlPkg::decodeCtrl_t decodeCtrl,
  input  armCtrlPkg::flags_t      ALUFlagsE,
  input  logic [1:0]              ALUResultLowE,   // Byte offset of the address
  output armCtrlPkg::aluOp_e      ALUControlE,
  output logic                    ALUSrcE,
  output logic                    BranchTakenE,
  output armCtrlPkg::flags_t      FlagsE,
  output armCtrlPkg::memCtrl_t    memCtrl          // Gated controls into Memory
);
  import armCtrlPkg::*;

  decodeCtrl_t          ctrlE;       // D to E stage register
  flags_t               flagsReg;
  flags_t               nextFlags;
  logic                 condEx;
  logic                 memAccess;
  logic [WordLanes-1:0] byteMask;

  // ======================================
  // Stage and flags registers
  // ======================================
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlE <= '0;
    end else if (!StallE) begin
      ctrlE <= FlushE ? '0 : decodeCtrl;   // Flush inserts a bubble
    end
  end

  // Written only by a passing flag-setting instruction as it leaves E
  always_ff @(posedge clk) begin
    if (rst) begin
      flagsReg <= '0;
    end else if (!StallE && condEx && (ctrlE.flagWrite != 2'b00)) begin
      flagsReg <= nextFlags;
    end
  end

  condUnit condUnit_i (
    .cond      (ctrlE.cond),
    .flags     (flagsReg),
    .aluFlags  (ALUFlagsE),
    .flagWrite (ctrlE.flagWrite),
    .condEx    (condEx),
    .nextFlags (nextFlags)
  );

  assign FlagsE       = flagsReg;
  assign ALUControlE  = ctrlE.aluControl;
  assign ALUSrcE      = ctrlE.aluSrc;
  assign BranchTakenE = ctrlE.branch & condEx;

  // ======================================
  // Byte mask
  // ======================================
  assign memAccess = (ctrlE.memWrite | ctrlE.memtoReg) & condEx;

  always_comb begin
    if (!memAccess) begin
      byteMask = '0;
    end else if (ctrlE.byteAccess) begin
      byteMask = {{(WordLanes-1){1'b0}}, 1'b1} << ALUResultLowE;   // One lane
    end else begin
      byteMask = '1;                                                // Whole word
    end
  end

  // Every side effect gated by the condition
  assign memCtrl.memWrite = ctrlE.memWrite & condEx;
  assign memCtrl.memtoReg = ctrlE.memtoReg & condEx;
  assign memCtrl.regWrite = ctrlE.regWrite & condEx;
  assign memCtrl.pcSrc    = ctrlE.pcSrc & condEx;
  assign memCtrl.byteMask = byteMask;

endmodule

`default_nettype wire

// ==== hw/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
  input  logic [31:0]             InstrD,
  output logic [1:0]              RegSrcD,     // Register read port selects
  output logic [1:0]              ImmSrcD,     // Immediate extension format
  output logic                    ALUSrcD,     // Immediate as ALU operand B
  output armCtrlPkg::decodeCtrl_t decodeCtrl   // Bundle registered into Execute
);
  import armCtrlPkg::*;

  instrClass_e instrClass;
  aluOp_e      dpOpcode;
  logic        iBit;
  logic        uBit;
  logic        bBit;
  logic        lBit;
  logic        sBit;
  logic        arithOp;     // Opcode produces C and V from the adder
  logic        compareOp;   // TST, TEQ, CMP, CMN write no register
  logic        rdIsPc;

  // ======================================
  // Field extraction
  // ======================================
  assign iBit     = InstrD[IBit];
  assign uBit     = InstrD[UBit];
  assign bBit     = InstrD[BBit];
  assign lBit     = InstrD[LBit];
  assign sBit     = InstrD[SBit];
  assign dpOpcode = aluOp_e'(InstrD[DpOpMsb:DpOpLsb]);
  assign rdIsPc   = (InstrD[RdMsb:RdLsb] == PcReg);

  assign arithOp   = dpOpcode inside {AluSub, AluRsb, AluAdd, AluAdc,
                                      AluSbc, AluRsc, AluCmp, AluCmn};
  assign compareOp = dpOpcode inside {AluTst, AluTeq, AluCmp, AluCmn};

  // Instruction class from the op bits
  always_comb begin
    case (InstrD[OpMsb:OpLsb])
      2'b00: instrClass = ClassDataProc;
      2'b01: begin
        // Register offset with bit 4 set is the undefined space
        if (iBit && InstrD[UndefBit]) begin
          instrClass = ClassNoOp;
        end else begin
          instrClass = ClassMemAccess;
        end
      end
      2'b10: instrClass = ClassBranch;
      default: instrClass = ClassNoOp;   // SWI and coprocessor space
    endcase
  end

  // ======================================
  // Main control generation
  // ======================================
  always_comb begin
    decodeCtrl            = '0;
    decodeCtrl.cond       = cond_e'(InstrD[CondMsb:CondLsb]);
    decodeCtrl.aluControl = AluAdd;      // Address and target adds
    RegSrcD               = 2'b00;
    ImmSrcD               = 2'b00;
    ALUSrcD               = 1'b0;

    case (instrClass)
      ClassDataProc: begin
        ALUSrcD               = iBit;    // Rotated 8-bit immediate
        decodeCtrl.aluControl = dpOpcode;
        decodeCtrl.regWrite   = ~compareOp;
        // Logical ops leave C and V alone
        decodeCtrl.flagWrite  = {sBit, sBit & arithOp};
      end
      ClassMemAccess: begin
        RegSrcD               = {~lBit, 1'b0};   // Stores read Rd as data
        ImmSrcD               = 2'b01;           // 12-bit offset
        ALUSrcD               = ~iBit;           // I clear means immediate offset
        decodeCtrl.aluControl = uBit ? AluAdd : AluSub;
        decodeCtrl.memWrite   = ~lBit;
        decodeCtrl.memtoReg   = lBit;
        decodeCtrl.regWrite   = lBit;
        decodeCtrl.byteAccess = bBit;
      end
      ClassBranch: begin
        RegSrcD           = 2'b01;       // PC as operand A
        ImmSrcD           = 2'b10;       // 24-bit word offset
        ALUSrcD           = 1'b1;
        decodeCtrl.branch = 1'b1;
      end
      default: begin
        // Undefined and SWI never execute
        decodeCtrl.cond = CondNv;
      end
    endcase

    decodeCtrl.aluSrc = ALUSrcD;
    // Any write to R15 redirects fetch
    decodeCtrl.pcSrc  = decodeCtrl.branch | (decodeCtrl.regWrite & rdIsPc);
  end

endmodule

`default_nettype wire

// ==== hw/memWbStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 StallM,
  input  logic                                 FlushM,
  input  logic                                 StallW,
  input  logic                                 FlushW,
  input  armCtrlPkg::memCtrl_t                 memCtrl,     // Gated controls from E
  output logic                                 MemWriteM,
  output logic                                 MemtoRegM,
  output logic                                 RegWriteM,
  output logic [armCtrlPkg::WordLanes-1:0]     ByteMaskM,
  output logic                                 MemtoRegW,
  output logic                                 RegWriteW,
  output logic                                 PCSrcW
);
  import armCtrlPkg::*;

  memCtrl_t ctrlM;    // E to M stage register
  wbCtrl_t  wbNext;   // Subset that survives into Writeback
  wbCtrl_t  ctrlW;    // M to W stage register

  // ======================================
  // Memory stage
  // ======================================
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlM <= '0;
    end else if (!StallM) begin
      ctrlM <= FlushM ? '0 : memCtrl;
    end
  end

  assign MemWriteM = ctrlM.memWrite;
  assign MemtoRegM = ctrlM.memtoReg;
  assign RegWriteM = ctrlM.regWrite;
  assign ByteMaskM = ctrlM.byteMask;

  // Mask and store enable end in M
  assign wbNext.memtoReg = ctrlM.memtoReg;
  assign wbNext.regWrite = ctrlM.regWrite;
  assign wbNext.pcSrc    = ctrlM.pcSrc;

  // ======================================
  // Writeback stage
  // ======================================
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlW <= '0;
    end else if (!StallW) begin
      ctrlW <= FlushW ? '0 : wbNext;   // Keeps loading while M is held
    end
  end

  assign MemtoRegW = ctrlW.memtoReg;
  assign RegWriteW = ctrlW.regWrite;
  assign PCSrcW    = ctrlW.pcSrc;      // Redirect fetch from the result

endmodule

`default_nettype wire

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -j 0 \
  -f armController.f \
  --top-module tbArmController \
  -Mdir "$buildDir" -o simArmController
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/simArmController" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "PASS: all tests" "$logFile"; then
  exit 0
fi
echo "Pass line not found in $logFile"
exit 1

// ==== verif/armControllerProperties.sv ====
`timescale 1ns/1ps
`default_nettype none

module armControllerProperties (
  input logic                                     clk,
  input logic                                     rst,
  input logic                                     stallA,    // Stall of the first stage
  input logic [$bits(armCtrlPkg::decodeCtrl_t)-1:0] stageA,  // Its register with zero padding
  input logic                                     stallB,    // Stall of the second register
  input logic [$bits(armCtrlPkg::decodeCtrl_t)-1:0] stageB,
  input logic [armCtrlPkg::WordLanes-1:0]         byteMask,
  input logic                                     condEx,    // Condition result in E
  input logic                                     memWrite   // Store enable leaving E or M
);

  // ========================================
  // Stalled stages hold
  // ========================================
  stageAHold: assert property (@(posedge clk) disable iff (rst) stallA |=> $stable(stageA))
    else $error("First stage register changed while stalled");

  stageBHold: assert property (@(posedge clk) disable iff (rst) stallB |=> $stable(stageB))
    else $error("Second stage register changed while stalled");

  // Zero, a single lane or the whole word
  maskShape: assert property (@(posedge clk) disable iff (rst)
    $onehot0(byteMask) || (byteMask == '1))
    else $error("Byte mask has an illegal lane pattern");

  // A failed condition must never store
  storeGate: assert property (@(posedge clk) disable iff (rst) !condEx |-> !memWrite)
    else $error("Store enabled by an instruction that failed its condition");

endmodule

bind executeStage armControllerProperties execProps_i (
  .clk      (clk),
  .rst      (rst),
  .stallA   (StallE),
  .stageA   (ctrlE),
  .stallB   (StallE),             // Flags register holds with the stage
  .stageB   ({13'b0, flagsReg}),
  .byteMask (memCtrl.byteMask),
  .condEx   (condEx),
  .memWrite (memCtrl.memWrite)
);

bind memWbStage armControllerProperties memWbProps_i (
  .clk      (clk),
  .rst      (rst),
  .stallA   (StallM),
  .stageA   ({9'b0, ctrlM}),
  .stallB   (StallW),
  .stageB   ({14'b0, ctrlW}),
  .byteMask (ctrlM.byteMask),
  .condEx   (1'b1),           // Gating already applied in E
  .memWrite (ctrlM.memWrite)
);

`default_nettype wire

// ==== verif/tbArmController.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbArmController;
  import armCtrlPkg::*;

  localparam int ClkPeriod      = 20;
  localparam int DriveDelay     = 2;    // Inputs change this long after the edge
  localparam int ResetCycles    = 16;
  localparam int TestCycles     = ResetCycles + 8 + 13 + 123 + 13 + 38;
  localparam int WatchdogCycles = TestCycles + 80;
  localparam logic [31:0] Seed  = 32'h3820_b9d0;

  logic        clk;
  logic        rst;
  logic [31:0] InstrD;
  flags_t      ALUFlagsE;
  logic [1:0]  ALUResultLowE;
  logic        StallE, FlushE, StallM, FlushM, StallW, FlushW;
  logic [1:0]  RegSrcD, ImmSrcD;
  logic        ALUSrcD, ALUSrcE, BranchTakenE;
  aluOp_e      ALUControlE;
  flags_t      FlagsE;
  logic        MemWriteM, MemtoRegM, RegWriteM;
  logic [3:0]  ByteMaskM;
  logic        MemtoRegW, RegWriteW, PCSrcW;
  logic [31:0] nopInstr;      // Undefined encoding that decodes to an empty bundle

  armController armController_i (.*);

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // ========================================
  // Reference model and instruction builder
  // ========================================
  function automatic logic condPasses(input cond_e cond, input flags_t f);
    logic [3:0] code;
    logic       base;
    code = cond;
    case (code[3:1])            // Even codes test and odd codes invert
      3'd0: base = f.z;
      3'd1: base = f.c;
      3'd2: base = f.n;
      3'd3: base = f.v;
      3'd4: base = f.c & ~f.z;
      3'd5: base = (f.n == f.v);
      3'd6: base = ~f.z & (f.n == f.v);
      default: base = 1'b1;
    endcase
    condPasses = (code[3:1] == 3'd7) ? ~code[0] : (base ^ code[0]);   // AL runs and NV never
  endfunction

  function automatic logic [31:0] dpInstr(input cond_e cond, input aluOp_e op,
                                          input logic imm, input logic s, input logic [3:0] rd);
    logic [31:0] instr;
    instr                  = '0;     // Op class 00
    instr[CondMsb:CondLsb] = cond;
    instr[IBit]            = imm;
    instr[DpOpMsb:DpOpLsb] = op;
    instr[SBit]            = s;
    instr[RdMsb:RdLsb]     = rd;
    dpInstr = instr;
  endfunction

  function automatic logic [31:0] memInstr(input cond_e cond, input logic load,
                                           input logic byteAcc, input logic up,
                                           input logic [3:0] rd);
    logic [31:0] instr;
    instr                  = '0;
    instr[CondMsb:CondLsb] = cond;
    instr[OpMsb:OpLsb]     = 2'b01;  // Immediate offset with I clear
    instr[UBit]            = up;
    instr[BBit]            = byteAcc;
    instr[LBit]            = load;
    instr[RdMsb:RdLsb]     = rd;
    memInstr = instr;
  endfunction

  function automatic logic [31:0] branchInstr(input cond_e cond);
    logic [31:0] instr;
    instr                  = 32'h0000_0010;   // Small forward offset
    instr[CondMsb:CondLsb] = cond;
    instr[OpMsb:OpLsb]     = 2'b10;
    branchInstr = instr;
  endfunction

  function automatic logic [31:0] undefInstr();
    logic [31:0] instr;
    instr                  = '0;
    instr[CondMsb:CondLsb] = CondAl;
    instr[OpMsb:OpLsb]     = 2'b01;
    instr[IBit]            = 1'b1;
    instr[UndefBit]        = 1'b1;
    undefInstr = instr;
  endfunction

  // ========================================
  // Compare tasks
  // ========================================
  task automatic reportFail(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkBit(input logic got, input logic exp, input string what);
    if (got !== exp) reportFail($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic checkSel(input logic [1:0] got, input logic [1:0] exp, input string what);
    if (got !== exp) reportFail($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic checkMask(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp) reportFail($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic checkFlags(input flags_t got, input flags_t exp, input string what);
    if (got !== exp) reportFail($sformatf("%s NZCV is %b, expected %b", what, got, exp));
  endtask

  task automatic checkAluOp(input aluOp_e got, input aluOp_e exp, input string what);
    if (got !== exp) reportFail($sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
  endtask

  // ========================================
  // Drive helpers
  // ========================================
  task automatic stepClock();
    @(posedge clk);
    #DriveDelay;
  endtask

  // Instruction enters E at the next edge and D falls back to a no-op
  task automatic issue(input logic [31:0] instr);
    InstrD = instr;
    stepClock();
    InstrD = nopInstr;
  endtask

  task automatic expectSelects(input logic [31:0] instr, input logic [1:0] regSrc,
                               input logic [1:0] immSrc, input logic aluSrc, input string what);
    InstrD = instr;
    #1;                          // Decode is combinational
    checkSel(RegSrcD, regSrc, {what, " RegSrcD"});
    checkSel(ImmSrcD, immSrc, {what, " ImmSrcD"});
    checkBit(ALUSrcD, aluSrc, {what, " ALUSrcD"});
    stepClock();
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic resetValues();
    checkBit(BranchTakenE, 1'b0, "BranchTakenE after reset");
    checkBit(MemWriteM, 1'b0, "MemWriteM after reset");
    checkBit(RegWriteM, 1'b0, "RegWriteM after reset");
    checkBit(MemtoRegM, 1'b0, "MemtoRegM after reset");
    checkMask(ByteMaskM, 4'b0000, "ByteMaskM after reset");
    checkBit(RegWriteW, 1'b0, "RegWriteW after reset");
    checkBit(MemtoRegW, 1'b0, "MemtoRegW after reset");
    checkBit(PCSrcW, 1'b0, "PCSrcW after reset");
    checkFlags(FlagsE, flags_t'(4'h0), "FlagsE after reset");
  endtask

  task automatic decodeSelects();
    expectSelects(dpInstr(CondAl, AluAdd, 1'b1, 1'b0, 4'd1), 2'b00, 2'b00, 1'b1, "DP imm");
    expectSelects(dpInstr(CondAl, AluOrr, 1'b0, 1'b0, 4'd1), 2'b00, 2'b00, 1'b0, "DP reg");
    expectSelects(memInstr(CondAl, 1'b1, 1'b0, 1'b1, 4'd2), 2'b00, 2'b01, 1'b1, "LDR");
    expectSelects(memInstr(CondAl, 1'b0, 1'b0, 1'b1, 4'd2), 2'b10, 2'b01, 1'b1, "STR");
    expectSelects(branchInstr(CondAl), 2'b01, 2'b10, 1'b1, "B");
    expectSelects(nopInstr, 2'b00, 2'b00, 1'b0, "undefined");
    issue(nopInstr);             // Undefined now in M
    checkBit(MemWriteM, 1'b0, "undefined MemWriteM");
    checkBit(RegWriteM, 1'b0, "undefined RegWriteM");
    checkMask(ByteMaskM, 4'b0000, "undefined ByteMaskM");
    issue(nopInstr);
    checkBit(RegWriteW, 1'b0, "undefined RegWriteW");
    checkBit(PCSrcW, 1'b0, "undefined PCSrcW");
  endtask

  task automatic memoryPipeline();
    logic [1:0] lane;
    for (int off = 0; off < 4; off++) begin
      lane = off[1:0];
      issue(memInstr(CondAl, 1'b0, 1'b1, lane[0], 4'd4));   // STRB that subtracts on even lanes
      checkAluOp(ALUControlE, lane[0] ? AluAdd : AluSub, "STRB offset direction");
      ALUResultLowE = lane;
      issue(nopInstr);
      checkBit(MemWriteM, 1'b1, "STRB MemWriteM");
      checkMask(ByteMaskM, 4'b0001 << lane, "STRB ByteMaskM");
    end
    ALUResultLowE = 2'b00;
    issue(memInstr(CondAl, 1'b1, 1'b0, 1'b1, 4'd5));        // LDR
    issue(nopInstr);
    checkMask(ByteMaskM, 4'b1111, "LDR ByteMaskM");
    issue(nopInstr);
    checkBit(RegWriteW, 1'b1, "LDR RegWriteW");
    checkBit(MemtoRegW, 1'b1, "LDR MemtoRegW");
  endtask

  task automatic conditionGating();
    logic [31:0] r;
    flags_t      aluFlags;
    cond_e       cond;
    repeat (40) begin
      r        = $urandom;
      aluFlags = r[3:0];
      cond     = cond_e'(r[7:4]);
      issue(dpInstr(CondAl, AluSub, 1'b1, 1'b1, 4'd2));     // SUBS sets all four
      ALUFlagsE = aluFlags;
      issue(dpInstr(cond, AluAdd, 1'b0, 1'b0, 4'd3));
      checkFlags(FlagsE, aluFlags, "flags after SUBS");
      ALUFlagsE = ~aluFlags;     // ADD without S must not land these
      issue(nopInstr);
      checkBit(RegWriteM, condPasses(cond, aluFlags), $sformatf("ADD %s RegWriteM", cond.name()));
      checkFlags(FlagsE, aluFlags, "flags kept by ADD");
    end
    issue(dpInstr(CondAl, AluSub, 1'b1, 1'b1, 4'd2));
    ALUFlagsE = flags_t'(4'b0011);
    issue(dpInstr(CondAl, AluAnd, 1'b0, 1'b1, 4'd2));       // ANDS touches only N and Z
    ALUFlagsE = flags_t'(4'b1100);
    issue(nopInstr);
    checkFlags(FlagsE, flags_t'(4'b1111), "ANDS keeps C and V");
  endtask

  task automatic stallAndFlush();
    issue(dpInstr(CondAl, AluAdd, 1'b0, 1'b0, 4'd3));
    StallE = 1'b1;
    InstrD = dpInstr(CondAl, AluSub, 1'b0, 1'b0, 4'd3);
    stepClock();
    checkAluOp(ALUControlE, AluAdd, "ALUControlE under StallE");
    StallE = 1'b0;
    stepClock();
    checkAluOp(ALUControlE, AluSub, "ALUControlE after StallE");
    InstrD = memInstr(CondAl, 1'b1, 1'b0, 1'b1, 4'd6);
    FlushE = 1'b1;
    stepClock();
    FlushE = 1'b0;
    InstrD = nopInstr;
    checkAluOp(ALUControlE, AluAnd, "ALUControlE after FlushE");
    checkBit(ALUSrcE, 1'b0, "ALUSrcE after FlushE");
    stepClock();
    checkBit(MemtoRegM, 1'b0, "MemtoRegM of flushed LDR");
    checkBit(RegWriteM, 1'b0, "RegWriteM of flushed LDR");
    issue(memInstr(CondAl, 1'b1, 1'b0, 1'b1, 4'd6));        // LDR into M
    issue(nopInstr);
    checkBit(RegWriteW, 1'b0, "RegWriteW before StallM");
    StallM = 1'b1;
    stepClock();
    checkBit(MemtoRegM, 1'b1, "MemtoRegM under StallM");
    checkMask(ByteMaskM, 4'b1111, "ByteMaskM under StallM");
    checkBit(RegWriteW, 1'b1, "RegWriteW loads under StallM");
    StallM = 1'b0;
    stepClock();
    checkBit(MemtoRegM, 1'b0, "MemtoRegM after StallM");
    StallW = 1'b1;               // LDR sits in W with a bubble behind it
    stepClock();
    checkBit(RegWriteW, 1'b1, "RegWriteW under StallW");
    StallW = 1'b0;
    stepClock();
    checkBit(RegWriteW, 1'b0, "RegWriteW after StallW");
    issue(memInstr(CondAl, 1'b1, 1'b0, 1'b1, 4'd6));
    FlushM = 1'b1;
    stepClock();
    FlushM = 1'b0;
    checkBit(MemtoRegM, 1'b0, "MemtoRegM after FlushM");
    checkMask(ByteMaskM, 4'b0000, "ByteMaskM after FlushM");
  endtask

  task automatic branchRedirect();
    logic [31:0] r;
    flags_t      f;
    for (int c = 0; c < 16; c++) begin
      r = $urandom;
      f = r[3:0];
      issue(dpInstr(CondAl, AluSub, 1'b1, 1'b1, 4'd2));
      ALUFlagsE = f;
      issue(branchInstr(cond_e'(c)));
      checkBit(BranchTakenE, condPasses(cond_e'(c), f), $sformatf("B cond %0d taken", c));
    end
    issue(nopInstr);
    issue(nopInstr);
    issue(dpInstr(CondAl, AluMov, 1'b0, 1'b0, PcReg));     // MOV to R15
    issue(nopInstr);
    checkBit(PCSrcW, 1'b0, "PCSrcW before MOV reaches W");
    issue(nopInstr);
    checkBit(PCSrcW, 1'b1, "PCSrcW for MOV to R15");
  endtask

  // ========================================
  // Run control
  // ========================================
  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout: tests did not finish within %0d clock cycles", WatchdogCycles);
    $display("FAIL: see errors above");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    void'($urandom(Seed));
    nopInstr      = undefInstr();
    rst           = 1'b1;
    InstrD        = nopInstr;
    ALUFlagsE     = flags_t'(4'h0);
    ALUResultLowE = 2'b00;
    StallE        = 1'b0;
    FlushE        = 1'b0;
    StallM        = 1'b0;
    FlushM        = 1'b0;
    StallW        = 1'b0;
    FlushW        = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    rst = 1'b0;
    resetValues();
    decodeSelects();
    memoryPipeline();
    conditionGating();
    stallAndFlush();
    branchRedirect();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire
